// ==== Bender.yml ====
package:
  name: masku

sources:
  - logic/masku_cfg_pkg.sv
  - logic/masku_insn_pkg.sv
  - logic/masku_insn_ctrl.sv
  - logic/masku_merge_alu.sv
  - logic/masku_result_queue.sv
  - logic/masku_top.sv
  - target: test
    files:
      - dv/masku_lane_agent.sv
      - dv/tb_masku.sv

// ==== dv/masku_lane_agent.sv ====
////////////////////////////////////////////////////////////
// One lane: operand words come from the testbench by count
////////////////////////////////////////////////////////////

module masku_lane_agent #(
  parameter int unsigned Lane = 0
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Words for the current counts, supplied by the testbench
  input  masku_cfg_pkg::elen_t a_word_i,
  input  masku_cfg_pkg::elen_t b_word_i,
  input  masku_cfg_pkg::elen_t m_word_i,
  output masku_cfg_pkg::elen_t a_o,
  output masku_cfg_pkg::elen_t b_o,
  output masku_cfg_pkg::elen_t m_o,
  output logic                 a_valid_o,
  output logic                 b_valid_o,
  output logic                 m_valid_o,
  input  logic                 ab_ready_i,
  input  logic                 m_ready_i,
  output int unsigned          ab_cnt_o,
  output int unsigned          m_cnt_o,
  // Write-back side
  input  logic                 req_i,
  output logic                 gnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] lfsr = 32'ha16c;
  logic        took_ab = 1'b0;
  logic        took_m = 1'b0;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  assign a_o = a_word_i;
  assign b_o = b_word_i;
  assign m_o = m_word_i;

  initial begin
    a_valid_o = 1'b0;
    b_valid_o = 1'b0;
    m_valid_o = 1'b0;
    gnt_o     = 1'b0;
    ab_cnt_o  = 0;
    m_cnt_o   = 0;
    // Lanes start at different points of the sequence
    for (int i = 0; i < Lane * 7; i++) begin
      lfsr = lfsr_step(lfsr);
    end
  end

  always @(posedge clk_i) begin
    took_ab <= ab_ready_i;
    took_m  <= m_ready_i;
  end

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      a_valid_o <= 1'b0;
      b_valid_o <= 1'b0;
      m_valid_o <= 1'b0;
      gnt_o     <= 1'b0;
    end else begin
      // Accepted words move on to the next count
      if (took_ab) begin
        ab_cnt_o  <= ab_cnt_o + 1;
      end
      if (took_m) begin
        m_cnt_o   <= m_cnt_o + 1;
      end
      // Held words stay valid until taken
      a_valid_o <= (a_valid_o && !took_ab) || take_bit();
      b_valid_o <= (b_valid_o && !took_ab) || take_bit();
      m_valid_o <= (m_valid_o && !took_m) || take_bit();
      gnt_o     <= req_i && take_bit();
    end
  end

endmodule : masku_lane_agent

// ==== dv/tb_masku.sv ====
////////////////////////////////////////////////////////////
// Two lanes; the model tracks beats in global order
////////////////////////////////////////////////////////////

module tb_masku;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NrLanes  = 2;
  localparam int unsigned Elen     = masku_cfg_pkg::ElenWidth;
  localparam int unsigned BeatBits = NrLanes * Elen;
  localparam int unsigned NumInsn  = 6;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic req_valid_i = 1'b0;
  logic req_ready_o, req_vm_i = 1'b1, done_o;
  masku_insn_pkg::vid_t  req_id_i = '0, done_id_o;
  masku_insn_pkg::vreg_t req_vd_i = '0;
  masku_insn_pkg::vlen_t req_vl_i = '0;
  masku_cfg_pkg::elen_t  [NrLanes-1:0] operand_a_i, operand_b_i, operand_m_i;
  logic [NrLanes-1:0] operand_a_valid_i, operand_b_valid_i, operand_m_valid_i;
  logic [NrLanes-1:0] operand_a_ready_o, operand_b_ready_o, operand_m_ready_o;
  logic [NrLanes-1:0] result_req_o, result_gnt_i;
  masku_cfg_pkg::vaddr_t [NrLanes-1:0] result_addr_o;
  masku_insn_pkg::vid_t  [NrLanes-1:0] result_id_o;
  masku_cfg_pkg::elen_t  [NrLanes-1:0] result_wdata_o;
  masku_cfg_pkg::strb_t  [NrLanes-1:0] result_be_o;

  // Model, indexed by global beat number
  int unsigned g_rem[64], g_midx[64], g_beat[64];
  logic        g_vm[64];
  int unsigned g_vd[64], g_id[64];
  int unsigned g_next = 0, m_next = 0;
  int unsigned r_cnt[NrLanes], ab_cnt[NrLanes], m_cnt[NrLanes];
  logic        busy = 1'b0, cur_vm = 1'b1;
  string       test_name = "reset";
  masku_cfg_pkg::elen_t  exp_wdata[NrLanes];
  masku_cfg_pkg::strb_t  exp_be[NrLanes];

  masku_top #(.NrLanes(NrLanes)) i_dut (.*);

  initial forever #2 clk_i = !clk_i;

  // Operand patterns by lane and word count
  function automatic masku_cfg_pkg::elen_t word_a(int unsigned l, int unsigned n);
    return {32'h9e37_79b9 * (n + 1) ^ l, 32'hc2b2_ae35 * (n + 3) + l};
  endfunction
  function automatic masku_cfg_pkg::elen_t word_b(int unsigned l, int unsigned n);
    return {32'h85eb_ca6b * (n + 5) + l, 32'h27d4_eb2f * (n + 7) ^ l};
  endfunction
  function automatic masku_cfg_pkg::elen_t word_m(int unsigned l, int unsigned n);
    return {32'h1656_67b1 * (n + 2) ^ l, 32'hff00_f0f0 ^ (n * 32'h0101_0101) ^ l};
  endfunction

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    masku_lane_agent #(.Lane(l)) i_agent (
      .clk_i, .rst_ni,
      .a_word_i(word_a(l, ab_cnt[l])), .b_word_i(word_b(l, ab_cnt[l])),
      .m_word_i(word_m(l, m_cnt[l])),
      .a_o(operand_a_i[l]), .b_o(operand_b_i[l]), .m_o(operand_m_i[l]),
      .a_valid_o(operand_a_valid_i[l]), .b_valid_o(operand_b_valid_i[l]),
      .m_valid_o(operand_m_valid_i[l]),
      .ab_ready_i(operand_a_ready_o[l]), .m_ready_i(operand_m_ready_o[l]),
      .ab_cnt_o(ab_cnt[l]), .m_cnt_o(m_cnt[l]),
      .req_i(result_req_o[l]), .gnt_o(result_gnt_i[l])
    );

    // Expected head result from the merge rules
    always_comb begin
      int unsigned          g;
      masku_cfg_pkg::elen_t wa;
      masku_cfg_pkg::elen_t wb;
      masku_cfg_pkg::elen_t wm;
      g  = r_cnt[l];
      wa = word_a(l, g);
      wb = word_b(l, g);
      wm = word_m(l, g_midx[g]);
      for (int unsigned j = 0; j < Elen; j++) begin
        exp_wdata[l][j] = (l * Elen + j < g_rem[g] && (g_vm[g] || wm[j])) ? wa[j] : wb[j];
      end
      for (int unsigned s = 0; s < Elen / 8; s++) begin
        exp_be[l][s] = (l * Elen + 8 * s < g_rem[g]);
      end
    end

    always_ff @(posedge clk_i) begin
      if (result_req_o[l] && result_gnt_i[l]) begin
        r_cnt[l] <= r_cnt[l] + 1;
      end
    end

    a_wdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] |-> result_wdata_o[l] == exp_wdata[l])
      else fail_mismatch("wdata", $sampled(exp_wdata[l]), $sampled(result_wdata_o[l]));
    a_be: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] |-> result_be_o[l] == exp_be[l])
      else fail_mismatch("byte enable", $sampled(exp_be[l]), $sampled(result_be_o[l]));
    a_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] |->
      result_addr_o[l] == g_vd[r_cnt[l]] * masku_cfg_pkg::VRegBeats + g_beat[r_cnt[l]])
      else fail_mismatch("address",
                         $sampled(g_vd[r_cnt[l]] * masku_cfg_pkg::VRegBeats +
                                  g_beat[r_cnt[l]]),
                         $sampled(result_addr_o[l]));
    a_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] |-> result_id_o[l] == g_id[r_cnt[l]])
      else fail_mismatch("result id", $sampled(g_id[r_cnt[l]]), $sampled(result_id_o[l]));
    // Pending request keeps its word until granted
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && !result_gnt_i[l] |=> result_req_o[l] && $stable(result_wdata_o[l]))
      else fail_plain("a pending result changed or dropped before its grant");
    // Words are only taken while the lane offers them
    a_ack_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      operand_a_ready_o[l] |-> operand_a_valid_i[l] && operand_b_valid_i[l] &&
      (cur_vm || operand_m_valid_i[l]))
      else fail_plain("an operand was acknowledged without a valid word");
    a_b_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
      operand_b_ready_o[l] == operand_a_ready_o[l])
      else fail_mismatch("b ready", $sampled(operand_a_ready_o[l]),
                         $sampled(operand_b_ready_o[l]));
    a_m_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
      operand_m_ready_o[l] == (operand_a_ready_o[l] && !cur_vm))
      else fail_mismatch("mask ready", $sampled(operand_a_ready_o[l] && !cur_vm),
                         $sampled(operand_m_ready_o[l]));
    // All beats of the instruction written, none extra
    a_beats: assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_o |-> r_cnt[l] == g_next)
      else fail_mismatch("beat count", $sampled(g_next), $sampled(r_cnt[l]));
  end : gen_lane

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_ready_o == (!busy || done_o))
    else fail_mismatch("req ready", $sampled(!busy || done_o), $sampled(req_ready_o));
  a_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> busy && done_id_o == req_id_i)
    else fail_mismatch("done id", $sampled(req_id_i), $sampled(done_id_o));

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      busy <= 1'b1;
    end else if (done_o) begin
      busy <= 1'b0;
    end
  end

  task automatic fail_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
    $display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic fail_plain(string what);
    $display("%s during %s", what, test_name);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // Fill the model, issue one instruction and wait for done
  task automatic run_insn(string name, int unsigned id, int unsigned vd,
                          int unsigned vl, logic vm);
    int unsigned beats;
    beats = (vl + BeatBits - 1) / BeatBits;
    for (int unsigned b = 0; b < beats; b++) begin
      g_rem[g_next + b]  = vl - b * BeatBits;
      g_vm[g_next + b]   = vm;
      g_vd[g_next + b]   = vd;
      g_id[g_next + b]   = id;
      g_beat[g_next + b] = b;
      g_midx[g_next + b] = m_next;
      if (!vm) begin
        m_next++;
      end
    end
    @(negedge clk_i);
    test_name   = name;
    g_next     += beats;
    cur_vm      = vm;
    req_id_i    = id;
    req_vd_i    = vd;
    req_vl_i    = vl;
    req_vm_i    = vm;
    req_valid_i = 1'b1;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (busy) begin
      @(negedge clk_i);
    end
  endtask

  // Watchdog
  initial begin
    repeat (200 * NumInsn + 10) @(posedge clk_i);
    $display("timeout: instructions did not complete in time");
    $display("TEST RESULT: FAIL");
    $fatal(1);
  end

  initial begin
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    run_insn("unmasked", 1, 2, 256, 1'b1);
    run_insn("tail", 2, 3, 200, 1'b1);
    run_insn("masked", 3, 5, 300, 1'b0);
    run_insn("masked_tail", 4, 7, 37, 1'b0);
    run_insn("full_register", 5, 31, 1024, 1'b1);
    run_insn("masked_full", 6, 0, 1024, 1'b0);
    repeat (4) @(negedge clk_i);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : tb_masku

// ==== logic/masku_cfg_pkg.sv ====
////////////////////////////////////////////////////////////
// Lane datapath widths; ElenWidth must be a multiple of 8
////////////////////////////////////////////////////////////

package masku_cfg_pkg;

  // Width of one lane word
  localparam int unsigned ElenWidth = 64;
  // Bytes in one lane word
  localparam int unsigned StrbWidth = ElenWidth / 8;
  // Lane words per vector register, in each lane
  localparam int unsigned VRegBeats = 8;

  // One lane data word
  typedef logic [ElenWidth-1:0] elen_t;

  // Byte enable of one lane word
  typedef logic [StrbWidth-1:0] strb_t;

  // Word address inside the VRF of one lane
  typedef logic [7:0] vaddr_t;

endpackage : masku_cfg_pkg

// ==== logic/masku_insn_ctrl.sv ====
////////////////////////////////////////////////////////////
// One instruction at a time; vl must be nonzero and fit in
// one register, i.e. at most VRegBeats beats
////////////////////////////////////////////////////////////

module masku_insn_ctrl #(
  parameter int unsigned NrLanes = 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer side
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  masku_insn_pkg::vid_t  req_id_i,
  input  masku_insn_pkg::vreg_t req_vd_i,
  input  masku_insn_pkg::vlen_t req_vl_i,
  input  logic                  req_vm_i,
  output logic                  done_o,
  output masku_insn_pkg::vid_t  done_id_o,
  // Towards the merge ALU
  output logic                  issue_valid_o,
  output masku_insn_pkg::vlen_t issue_remaining_o,
  output logic [2:0]            issue_beat_o,
  output masku_insn_pkg::vreg_t issue_vd_o,
  output logic                  issue_vm_o,
  output masku_insn_pkg::vid_t  issue_id_o,
  input  logic                  beat_fire_i,
  // From the result queue
  input  logic                  pop_i
);

  // Mask bits covered by one beat over all lanes
  localparam int unsigned BeatWidth = NrLanes * masku_cfg_pkg::ElenWidth;

  masku_insn_pkg::ctrl_state_e state_d, state_q;

  // Accepted instruction
  masku_insn_pkg::vid_t  id_q;
  masku_insn_pkg::vreg_t vd_q;
  logic                  vm_q;

  // Bits still to issue, and beat index inside the register
  masku_insn_pkg::vlen_t remaining_d, remaining_q;
  logic [2:0]            beat_d, beat_q;
  // Beats not yet written back to the lanes
  masku_insn_pkg::vlen_t commit_cnt_d, commit_cnt_q;

  logic done_d;
  logic req_fire;

  // Only an idle unit takes a new instruction
  assign req_ready_o = (state_q == masku_insn_pkg::CtrlIdle);
  assign req_fire    = req_valid_i && req_ready_o;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_comb begin : p_ctrl
    state_d      = state_q;
    remaining_d  = remaining_q;
    beat_d       = beat_q;
    commit_cnt_d = commit_cnt_q;
    done_d       = 1'b0;

    unique case (state_q)
      masku_insn_pkg::CtrlIdle: begin
        if (req_fire) begin
          state_d      = masku_insn_pkg::CtrlIssue;
          remaining_d  = req_vl_i;
          beat_d       = '0;
          // ceil(vl / BeatWidth)
          commit_cnt_d = masku_insn_pkg::vlen_t'((32'(req_vl_i) + BeatWidth - 1) / BeatWidth);
        end
      end
      masku_insn_pkg::CtrlIssue: begin
        if (beat_fire_i) begin
          beat_d = beat_q + 3'd1;
          // Saturate at zero on the tail beat
          if (remaining_q > BeatWidth) begin
            remaining_d = masku_insn_pkg::vlen_t'(remaining_q - BeatWidth);
          end else begin
            remaining_d = '0;
            state_d     = masku_insn_pkg::CtrlDrain;
          end
        end
      end
      masku_insn_pkg::CtrlDrain: begin
        // Last beat leaves the queue
        if (pop_i && commit_cnt_q == 16'd1) begin
          state_d = masku_insn_pkg::CtrlIdle;
          done_d  = 1'b1;
        end
      end
      default: state_d = masku_insn_pkg::CtrlIdle;
    endcase

    // Earlier beats may be written while the tail still issues
    if (pop_i) begin
      commit_cnt_d = commit_cnt_q - 16'd1;
    end
  end : p_ctrl

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      state_q      <= masku_insn_pkg::CtrlIdle;
      remaining_q  <= '0;
      beat_q       <= '0;
      commit_cnt_q <= '0;
      done_o       <= 1'b0;
    end else begin
      state_q      <= state_d;
      remaining_q  <= remaining_d;
      beat_q       <= beat_d;
      commit_cnt_q <= commit_cnt_d;
      done_o       <= done_d;
    end
  end : p_ctrl_ff

  // Instruction fields, held until the next accept
  always_ff @(posedge clk_i) begin : p_insn_ff
    if (req_fire) begin
      id_q <= req_id_i;
      vd_q <= req_vd_i;
      vm_q <= req_vm_i;
    end
  end : p_insn_ff

  assign issue_valid_o     = (state_q == masku_insn_pkg::CtrlIssue);
  assign issue_remaining_o = remaining_q;
  assign issue_beat_o      = beat_q;
  assign issue_vd_o        = vd_q;
  assign issue_vm_o        = vm_q;
  assign issue_id_o        = id_q;
  // Id is still stable in the done cycle
  assign done_id_o         = id_q;

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Busy from accept until done
  a_busy_until_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_fire |=> (!req_ready_o until done_o));

  a_vl_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_fire |-> (req_vl_i != '0) && (req_vl_i <= masku_cfg_pkg::VRegBeats * BeatWidth));

  a_pop_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> (commit_cnt_q != '0));

endmodule : masku_insn_ctrl

// ==== logic/masku_insn_pkg.sv ====
////////////////////////////////////////////////////////////
// Instruction fields seen by the mask unit
////////////////////////////////////////////////////////////

package masku_insn_pkg;

  // Instruction id given by the sequencer
  typedef logic [2:0] vid_t;

  // Vector register number
  typedef logic [4:0] vreg_t;

  // Vector length, counted in mask bits
  typedef logic [15:0] vlen_t;

  // Instruction control
  // Issue while beats are left to compute, drain while results are written
  typedef enum logic [1:0] {
    CtrlIdle,
    CtrlIssue,
    CtrlDrain
  } ctrl_state_e;

endpackage : masku_insn_pkg

// ==== logic/masku_merge_alu.sv ====
////////////////////////////////////////////////////////////
// Combinational; lane l bit j is beat bit l*ElenWidth+j
////////////////////////////////////////////////////////////

module masku_merge_alu #(
  parameter int unsigned NrLanes = 1
) (
  // Current instruction
  input  logic                               issue_valid_i,
  input  masku_insn_pkg::vlen_t              issue_remaining_i,
  input  logic [2:0]                         issue_beat_i,
  input  masku_insn_pkg::vreg_t              issue_vd_i,
  input  logic                               issue_vm_i,
  input  masku_insn_pkg::vid_t               issue_id_i,
  // ALU result words
  input  masku_cfg_pkg::elen_t [NrLanes-1:0] operand_a_i,
  input  logic [NrLanes-1:0]                 operand_a_valid_i,
  output logic [NrLanes-1:0]                 operand_a_ready_o,
  // Old destination words
  input  masku_cfg_pkg::elen_t [NrLanes-1:0] operand_b_i,
  input  logic [NrLanes-1:0]                 operand_b_valid_i,
  output logic [NrLanes-1:0]                 operand_b_ready_o,
  // Mask words
  input  masku_cfg_pkg::elen_t [NrLanes-1:0] operand_m_i,
  input  logic [NrLanes-1:0]                 operand_m_valid_i,
  output logic [NrLanes-1:0]                 operand_m_ready_o,
  // Result queue
  input  logic                               queue_full_i,
  output logic                               beat_fire_o,
  output masku_cfg_pkg::elen_t [NrLanes-1:0] push_wdata_o,
  output masku_cfg_pkg::strb_t [NrLanes-1:0] push_be_o,
  output masku_cfg_pkg::vaddr_t              push_addr_o,
  output masku_insn_pkg::vid_t               push_id_o
);

  localparam int unsigned ElenWidth = masku_cfg_pkg::ElenWidth;
  localparam int unsigned StrbWidth = masku_cfg_pkg::StrbWidth;

  // Per-bit select of "a" over the whole beat
  masku_cfg_pkg::elen_t [NrLanes-1:0] bit_enable;
  logic                               operands_valid;

  // Handshake
  // Mask words are only waited for on masked instructions
  assign operands_valid = &operand_a_valid_i && &operand_b_valid_i &&
                          (issue_vm_i || &operand_m_valid_i);
  assign beat_fire_o    = issue_valid_i && operands_valid && !queue_full_i;

  // All words of a beat are taken together
  assign operand_a_ready_o = {NrLanes{beat_fire_o}};
  assign operand_b_ready_o = {NrLanes{beat_fire_o}};
  assign operand_m_ready_o = {NrLanes{beat_fire_o && !issue_vm_i}};

  always_comb begin : p_enable
    for (int unsigned l = 0; l < NrLanes; l++) begin
      // Body bit, and either unmasked or mask bit set
      for (int unsigned j = 0; j < ElenWidth; j++) begin
        bit_enable[l][j] = (l * ElenWidth + j < issue_remaining_i) &&
                           (issue_vm_i || operand_m_i[l][j]);
      end
      // Byte written when its first bit is in the body
      for (int unsigned s = 0; s < StrbWidth; s++) begin
        push_be_o[l][s] = (l * ElenWidth + 8 * s < issue_remaining_i);
      end
    end
  end : p_enable

  // Merge, "a" where enabled and "b" elsewhere
  assign push_wdata_o = (operand_a_i & bit_enable) | (operand_b_i & ~bit_enable);

  // Register base plus beat index
  assign push_addr_o = masku_cfg_pkg::vaddr_t'(issue_vd_i * masku_cfg_pkg::VRegBeats +
                                               issue_beat_i);
  assign push_id_o   = issue_id_i;

endmodule : masku_merge_alu

// ==== logic/masku_result_queue.sv ====
////////////////////////////////////////////////////////////
// Two entries; a lane may only be granted while it requests
////////////////////////////////////////////////////////////

module masku_result_queue #(
  parameter int unsigned NrLanes = 1
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Push side, from the merge ALU
  input  logic                                push_i,
  input  masku_cfg_pkg::elen_t  [NrLanes-1:0] push_wdata_i,
  input  masku_cfg_pkg::strb_t  [NrLanes-1:0] push_be_i,
  input  masku_cfg_pkg::vaddr_t               push_addr_i,
  input  masku_insn_pkg::vid_t                push_id_i,
  output logic                                full_o,
  // Head entry fully written
  output logic                                pop_o,
  // Write-back to the lanes
  output logic                  [NrLanes-1:0] result_req_o,
  output masku_cfg_pkg::vaddr_t [NrLanes-1:0] result_addr_o,
  output masku_cfg_pkg::elen_t  [NrLanes-1:0] result_wdata_o,
  output masku_cfg_pkg::strb_t  [NrLanes-1:0] result_be_o,
  output masku_insn_pkg::vid_t  [NrLanes-1:0] result_id_o,
  input  logic                  [NrLanes-1:0] result_gnt_i
);

  localparam int unsigned Depth = 2;

  // Payload, shared address and id per entry
  masku_cfg_pkg::elen_t  [Depth-1:0][NrLanes-1:0] wdata_q;
  masku_cfg_pkg::strb_t  [Depth-1:0][NrLanes-1:0] be_q;
  masku_cfg_pkg::vaddr_t [Depth-1:0]              addr_q;
  masku_insn_pkg::vid_t  [Depth-1:0]              id_q;

  // Lanes of each entry still waiting for a grant
  logic [Depth-1:0][NrLanes-1:0] valid_d, valid_q;
  logic                          wr_ptr_q;
  logic                          rd_ptr_q;
  logic [1:0]                    cnt_q;
  // Head lanes left after this cycle's grants
  logic [NrLanes-1:0]            head_left;

  assign full_o    = (cnt_q == Depth);
  assign head_left = valid_q[rd_ptr_q] & ~result_gnt_i;
  // Grants of one entry may be spread over several cycles
  assign pop_o     = (cnt_q != '0) && (head_left == '0);

  always_comb begin : p_valid
    valid_d           = valid_q;
    valid_d[rd_ptr_q] = head_left;
    // Push never hits the head of a nonempty queue
    if (push_i) begin
      valid_d[wr_ptr_q] = '1;
    end
  end : p_valid

  ////////////////////////////////////////////////////////////
  // Ring state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ring_ff
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      if (push_i) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop_o) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      if (push_i && !pop_o) begin
        cnt_q <= cnt_q + 2'd1;
      end else if (!push_i && pop_o) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end : p_ring_ff

  always_ff @(posedge clk_i) begin : p_payload_ff
    if (push_i) begin
      wdata_q[wr_ptr_q] <= push_wdata_i;
      be_q[wr_ptr_q]    <= push_be_i;
      addr_q[wr_ptr_q]  <= push_addr_i;
      id_q[wr_ptr_q]    <= push_id_i;
    end
  end : p_payload_ff

  assign result_req_o   = valid_q[rd_ptr_q];
  assign result_wdata_o = wdata_q[rd_ptr_q];
  assign result_be_o    = be_q[rd_ptr_q];

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    assign result_addr_o[l] = addr_q[rd_ptr_q];
    assign result_id_o[l]   = id_q[rd_ptr_q];

    a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_gnt_i[l] |-> result_req_o[l]);

    // Pending request keeps its payload until granted
    a_payload_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && !result_gnt_i[l] |=> result_req_o[l] &&
      $stable(result_wdata_o[l]) && $stable(result_be_o[l]) &&
      $stable(result_addr_o[l]) && $stable(result_id_o[l]));
  end : gen_lane

endmodule : masku_result_queue

// ==== logic/masku_top.sv ====
////////////////////////////////////////////////////////////
// Mask-logical merge only; one beat is NrLanes*ElenWidth bits
////////////////////////////////////////////////////////////

module masku_top #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Sequencer
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  masku_insn_pkg::vid_t                req_id_i,
  input  masku_insn_pkg::vreg_t               req_vd_i,
  input  masku_insn_pkg::vlen_t               req_vl_i,
  input  logic                                req_vm_i,
  output logic                                done_o,
  output masku_insn_pkg::vid_t                done_id_o,
  // Lane operands
  input  masku_cfg_pkg::elen_t  [NrLanes-1:0] operand_a_i,
  input  logic                  [NrLanes-1:0] operand_a_valid_i,
  output logic                  [NrLanes-1:0] operand_a_ready_o,
  input  masku_cfg_pkg::elen_t  [NrLanes-1:0] operand_b_i,
  input  logic                  [NrLanes-1:0] operand_b_valid_i,
  output logic                  [NrLanes-1:0] operand_b_ready_o,
  input  masku_cfg_pkg::elen_t  [NrLanes-1:0] operand_m_i,
  input  logic                  [NrLanes-1:0] operand_m_valid_i,
  output logic                  [NrLanes-1:0] operand_m_ready_o,
  // Lane write-back
  output logic                  [NrLanes-1:0] result_req_o,
  output masku_cfg_pkg::vaddr_t [NrLanes-1:0] result_addr_o,
  output masku_insn_pkg::vid_t  [NrLanes-1:0] result_id_o,
  output masku_cfg_pkg::elen_t  [NrLanes-1:0] result_wdata_o,
  output masku_cfg_pkg::strb_t  [NrLanes-1:0] result_be_o,
  input  logic                  [NrLanes-1:0] result_gnt_i
);

  // Issue bundle
  logic                  issue_valid;
  masku_insn_pkg::vlen_t issue_remaining;
  logic [2:0]            issue_beat;
  masku_insn_pkg::vreg_t issue_vd;
  logic                  issue_vm;
  masku_insn_pkg::vid_t  issue_id;

  // Beat fire doubles as queue push
  logic                               beat_fire;
  masku_cfg_pkg::elen_t [NrLanes-1:0] push_wdata;
  masku_cfg_pkg::strb_t [NrLanes-1:0] push_be;
  masku_cfg_pkg::vaddr_t              push_addr;
  masku_insn_pkg::vid_t               push_id;
  logic                               queue_full;
  logic                               pop;

  masku_insn_ctrl #(.NrLanes(NrLanes)) i_insn_ctrl (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_id_i, .req_vd_i, .req_vl_i, .req_vm_i,
    .done_o, .done_id_o,
    .issue_valid_o(issue_valid), .issue_remaining_o(issue_remaining),
    .issue_beat_o(issue_beat), .issue_vd_o(issue_vd),
    .issue_vm_o(issue_vm), .issue_id_o(issue_id),
    .beat_fire_i(beat_fire), .pop_i(pop)
  );

  masku_merge_alu #(.NrLanes(NrLanes)) i_merge_alu (
    .issue_valid_i(issue_valid), .issue_remaining_i(issue_remaining),
    .issue_beat_i(issue_beat), .issue_vd_i(issue_vd),
    .issue_vm_i(issue_vm), .issue_id_i(issue_id),
    .operand_a_i, .operand_a_valid_i, .operand_a_ready_o,
    .operand_b_i, .operand_b_valid_i, .operand_b_ready_o,
    .operand_m_i, .operand_m_valid_i, .operand_m_ready_o,
    .queue_full_i(queue_full), .beat_fire_o(beat_fire),
    .push_wdata_o(push_wdata), .push_be_o(push_be),
    .push_addr_o(push_addr), .push_id_o(push_id)
  );

  masku_result_queue #(.NrLanes(NrLanes)) i_result_queue (
    .clk_i, .rst_ni,
    .push_i(beat_fire), .push_wdata_i(push_wdata), .push_be_i(push_be),
    .push_addr_i(push_addr), .push_id_i(push_id),
    .full_o(queue_full), .pop_o(pop),
    .result_req_o, .result_addr_o, .result_wdata_o, .result_be_o, .result_id_o,
    .result_gnt_i
  );

endmodule : masku_top

// ==== sources.f ====
logic/masku_cfg_pkg.sv
logic/masku_insn_pkg.sv
logic/masku_insn_ctrl.sv
logic/masku_merge_alu.sv
logic/masku_result_queue.sv
logic/masku_top.sv
dv/masku_lane_agent.sv
dv/tb_masku.sv
